// ==== hdl/grad_pkg.sv ====
`default_nettype none

package grad_pkg;

    // Image and gradient memories share one address width (256 x 256 max).
    localparam int ADDR_W = 16;

    // One pixel on the stream, tagged with its raster position.
    typedef struct packed {
        logic              valid;
        logic              first_col; // Column 0.
        logic              first_row; // Row 0.
        logic              last;      // Final pixel of the image.
        logic [ADDR_W-1:0] addr;
        logic [7:0]        pix;
    } pix_beat_t;

    // One difference result from the horizontal or vertical unit.
    typedef struct packed {
        logic              valid;
        logic              last;
        logic [ADDR_W-1:0] addr;
        logic signed [9:0] diff;
    } diff_t;

    // Gradient memory word with gx in the upper half.
    typedef struct packed {
        logic signed [9:0] gx;
        logic signed [9:0] gy;
    } grad_word_t;

    typedef enum logic [1:0] {
        SCAN_IDLE  = 2'd0,
        SCAN_READ  = 2'd1,
        SCAN_DRAIN = 2'd2,
        SCAN_DONE  = 2'd3
    } scan_state_t;

    // APB register offsets.
    typedef enum logic [7:0] {
        REG_CTRL   = 8'h00, // Bit 0 is start.
        REG_STATUS = 8'h04  // Bit 0 is busy, bit 1 is done.
    } reg_addr_t;

endpackage

`default_nettype wire

// ==== hdl/grad_apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module grad_apb_regs (
    input  wire         clk,
    input  wire         reset,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [7:0]  paddr,
    input  wire  [31:0] pwdata,
    input  wire         busy,
    input  wire         done,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        start
);
    import grad_pkg::*;

    logic access;  // APB access phase.
    logic addr_ok;
    logic ctrl_wr;

    assign access  = psel && penable;
    assign addr_ok = (paddr == REG_CTRL) || (paddr == REG_STATUS);
    assign ctrl_wr = access && pwrite && (paddr == REG_CTRL);

    // No wait states.
    assign pready  = 1'b1;
    assign pslverr = access && !addr_ok;

    // CTRL is write only; only STATUS returns data.
    always_comb begin
        prdata = '0;
        if (psel && !pwrite && (paddr == REG_STATUS)) begin
            prdata = {30'd0, done, busy};
        end
    end

    // A start written during a running scan is dropped.
    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= ctrl_wr && pwdata[0] && !busy;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/grad_scan_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module grad_scan_ctrl #(
    parameter int IMG_W = 16,
    parameter int IMG_H = 16
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           start,
    input  wire  [7:0]                    img_di,
    input  wire                           last_wr,
    output logic                          img_rd,
    output logic [grad_pkg::ADDR_W-1:0]   img_addr,
    output grad_pkg::pix_beat_t           beat,
    output logic                          busy,
    output logic                          done
);
    import grad_pkg::*;

    scan_state_t       state;
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] col;
    logic [ADDR_W-1:0] row;
    logic              col_end;
    logic              last_rd;

    // Position tags of the read in flight, lined up with img_di.
    logic              tag_valid;
    logic              tag_first_col;
    logic              tag_first_row;
    logic              tag_last;
    logic [ADDR_W-1:0] tag_addr;

    assign col_end = (col == ADDR_W'(IMG_W - 1));
    assign last_rd = col_end && (row == ADDR_W'(IMG_H - 1));

    assign img_rd   = (state == SCAN_READ);
    assign img_addr = rd_addr;
    assign busy     = (state == SCAN_READ) || (state == SCAN_DRAIN);
    assign done     = (state == SCAN_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= SCAN_IDLE;
            rd_addr <= '0;
            col     <= '0;
            row     <= '0;
        end else begin
            case (state)
                SCAN_IDLE, SCAN_DONE: begin
                    if (start) begin
                        state   <= SCAN_READ;
                        rd_addr <= '0;
                        col     <= '0;
                        row     <= '0;
                    end
                end
                SCAN_READ: begin
                    rd_addr <= rd_addr + 1'b1;
                    if (col_end) begin
                        col <= '0;
                        row <= row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                    if (last_rd) state <= SCAN_DRAIN; // Pipeline still holds 3 pixels.
                end
                SCAN_DRAIN: begin
                    if (last_wr) state <= SCAN_DONE;
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_valid <= 1'b0;
            tag_last  <= 1'b0;
        end else begin
            tag_valid <= img_rd;
            tag_last  <= img_rd && last_rd;
        end
    end

    always_ff @(posedge clk) begin
        tag_first_col <= (col == '0);
        tag_first_row <= (row == '0);
        tag_addr      <= rd_addr;
    end

    // Pixel data comes straight from the memory.
    assign beat = '{valid:     tag_valid,
                    first_col: tag_first_col,
                    first_row: tag_first_row,
                    last:      tag_last,
                    addr:      tag_addr,
                    pix:       img_di};

endmodule

`default_nettype wire

// ==== hdl/grad_horiz.sv ====
`timescale 1ns/100ps
`default_nettype none

module grad_horiz (
    input  wire                  clk,
    input  wire                  reset,
    input  grad_pkg::pix_beat_t  beat,
    output grad_pkg::diff_t      hdiff
);
    logic [7:0]        prev_pix; // Left neighbour of the current pixel.
    logic signed [9:0] diff;

    always_comb begin
        if (beat.first_col) begin
            diff = '0;
        end else begin
            diff = $signed({2'b00, beat.pix}) - $signed({2'b00, prev_pix});
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid) prev_pix <= beat.pix;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hdiff.valid <= 1'b0;
            hdiff.last  <= 1'b0;
        end else begin
            hdiff.valid <= beat.valid;
            hdiff.last  <= beat.valid && beat.last;
            hdiff.addr  <= beat.addr;
            hdiff.diff  <= diff;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/grad_vert.sv ====
`timescale 1ns/100ps
`default_nettype none

module grad_vert #(
    parameter int IMG_W = 16
) (
    input  wire                  clk,
    input  wire                  reset,
    input  grad_pkg::pix_beat_t  beat,
    output grad_pkg::diff_t      vdiff
);
    // One full row of pixels; entry IMG_W-1 is the pixel directly above.
    logic [7:0]        line_buf [IMG_W];
    logic [7:0]        above;
    logic signed [9:0] diff;

    assign above = line_buf[IMG_W-1];

    always_comb begin
        if (beat.first_row) begin
            diff = '0; // Nothing above row 0.
        end else begin
            diff = $signed({2'b00, beat.pix}) - $signed({2'b00, above});
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            line_buf[0] <= beat.pix;
            for (int i = 1; i < IMG_W; i++) begin
                line_buf[i] <= line_buf[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vdiff.valid <= 1'b0;
            vdiff.last  <= 1'b0;
        end else begin
            vdiff.valid <= beat.valid;
            vdiff.last  <= beat.valid && beat.last;
            vdiff.addr  <= beat.addr;
            vdiff.diff  <= diff;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/grad_pack_wr.sv ====
`timescale 1ns/100ps
`default_nettype none

module grad_pack_wr (
    input  wire                           clk,
    input  wire                           reset,
    input  grad_pkg::diff_t               hdiff,
    input  grad_pkg::diff_t               vdiff,
    output logic                          grad_wr,
    output logic [grad_pkg::ADDR_W-1:0]   grad_addr,
    output grad_pkg::grad_word_t          grad_do,
    output logic                          last_wr
);
    logic pair_valid;

    // Both units run in lockstep, so their results pair up each cycle.
    assign pair_valid = hdiff.valid && vdiff.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
            last_wr <= 1'b0;
        end else begin
            grad_wr <= pair_valid;
            last_wr <= pair_valid && hdiff.last && vdiff.last; // Ends the scan.
        end
    end

    always_ff @(posedge clk) begin
        grad_addr  <= hdiff.addr;
        grad_do.gx <= hdiff.diff;
        grad_do.gy <= vdiff.diff;
    end

endmodule

`default_nettype wire

// ==== hdl/grad_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module grad_top #(
    parameter int IMG_W = 16,
    parameter int IMG_H = 16
) (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire  [7:0]                    paddr,
    input  wire  [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  wire  [7:0]                    img_di,
    output logic                          img_rd,
    output logic [grad_pkg::ADDR_W-1:0]   img_addr,
    output logic                          grad_wr,
    output logic [grad_pkg::ADDR_W-1:0]   grad_addr,
    output grad_pkg::grad_word_t          grad_do,
    output logic                          done
);
    import grad_pkg::*;

    logic      start;
    logic      busy;
    logic      last_wr;
    pix_beat_t beat;   // Shared by both difference units.
    diff_t     hdiff;
    diff_t     vdiff;

    grad_apb_regs i_regs (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .busy    (busy),
        .done    (done),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .start   (start)
    );

    grad_scan_ctrl #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_scan (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .img_di   (img_di),
        .last_wr  (last_wr),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .beat     (beat),
        .busy     (busy),
        .done     (done)
    );

    grad_horiz i_horiz (
        .clk   (clk),
        .reset (reset),
        .beat  (beat),
        .hdiff (hdiff)
    );

    grad_vert #(.IMG_W(IMG_W)) i_vert (
        .clk   (clk),
        .reset (reset),
        .beat  (beat),
        .vdiff (vdiff)
    );

    grad_pack_wr i_pack (
        .clk       (clk),
        .reset     (reset),
        .hdiff     (hdiff),
        .vdiff     (vdiff),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .last_wr   (last_wr)
    );

endmodule

`default_nettype wire

// ==== dv/grad_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module grad_tb;
    import grad_pkg::*;

    localparam int IMG_W = 16;
    localparam int IMG_H = 16;
    localparam int NPIX = IMG_W * IMG_H;
    localparam int RUN_CYCLES = NPIX + 20;              // Scan, drain and APB traffic.
    localparam int MAX_CYCLES = 4 * (4 * RUN_CYCLES + 20); // Four scans plus reset.

    logic                clk = 1'b0;
    logic                reset;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [7:0]          paddr;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    logic [7:0]          img_di = 8'h00;
    logic                img_rd;
    logic [ADDR_W-1:0]   img_addr;
    logic                grad_wr;
    logic [ADDR_W-1:0]   grad_addr;
    grad_word_t          grad_do;
    logic                done;

    logic [7:0]          image [NPIX];   // Image memory contents.
    grad_word_t          capture [NPIX]; // Last word written per address.
    int                  wr_count [NPIX];
    logic                rd_pend = 1'b0;
    logic [ADDR_W-1:0]   pend_addr = '0;
    logic                done_q = 1'b0;
    int                  seed = 47932;
    int                  cycle = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  rd_count;
    int                  wr_total;
    int                  first_rd;
    int                  first_wr;
    int                  last_wr_cyc;
    int                  done_rise;

    grad_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) i_dut (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .img_di    (img_di),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // Image memory answers a read one cycle later.
    always @(negedge clk) begin
        if (rd_pend) img_di <= image[pend_addr];
        rd_pend   <= img_rd;
        pend_addr <= img_addr;
    end

    // Cycle counter and gradient memory capture.
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (img_rd) begin
            check("image read address", rd_count, img_addr); // Raster order from 0.
            rd_count++;
            if (first_rd < 0) first_rd = cycle;
        end
        if (grad_wr) begin
            wr_total++;
            last_wr_cyc = cycle;
            if (first_wr < 0) first_wr = cycle;
            if (grad_addr < NPIX) begin
                capture[grad_addr] = grad_do;
                wr_count[grad_addr]++;
            end else begin
                errors++;
                $display("Gradient write to address %0d lies outside the image", grad_addr);
            end
        end
        if (done && !done_q && done_rise < 0) done_rise = cycle;
        done_q = done;
    end

    task automatic report_and_finish();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        while (cycle < MAX_CYCLES) @(negedge clk);
        errors++;
        $display("Run stopped after %0d cycles because the scans never finished", MAX_CYCLES);
        report_and_finish();
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    // Backward differences that are zero in column 0 and row 0.
    function automatic grad_word_t ref_word(input int idx);
        int         gx;
        int         gy;
        grad_word_t word;
        gx = (idx % IMG_W == 0) ? 0 : int'(image[idx]) - int'(image[idx - 1]);
        gy = (idx / IMG_W == 0) ? 0 : int'(image[idx]) - int'(image[idx - IMG_W]);
        word.gx = 10'(gx);
        word.gy = 10'(gy);
        return word;
    endfunction

    // One APB transfer; response sampled at the end of the access phase.
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        rdata   = prdata;
        err     = pslverr;
        check("apb pready", 1, pready);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic fill_ramp();
        for (int i = 0; i < NPIX; i++) image[i] = 8'(i % IMG_W + 16 * (i / IMG_W));
    endtask

    task automatic fill_random();
        for (int i = 0; i < NPIX; i++) image[i] = 8'($random(seed));
    endtask

    task automatic start_scan(input string name);
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < NPIX; i++) begin
            capture[i]  = '0;
            wr_count[i] = 0;
        end
        rd_count    = 0;
        wr_total    = 0;
        first_rd    = -1;
        first_wr    = -1;
        last_wr_cyc = -1;
        done_rise   = -1;
        apb_access(1'b1, REG_CTRL, 32'h1, rdata, err);
        check({name, " start pslverr"}, 0, err);
        @(negedge clk); // Reads begin the cycle after the start pulse.
        check({name, " done cleared"}, 0, done);
        check({name, " img_rd active"}, 1, img_rd);
    endtask

    task automatic finish_scan(input string name);
        logic [31:0] status;
        logic        err;
        while (!done) @(negedge clk);
        @(negedge clk);
        check({name, " read count"}, NPIX, rd_count);
        check({name, " write count"}, NPIX, wr_total);
        for (int i = 0; i < NPIX; i++) begin
            check($sformatf("%s writes to address %0d", name, i), 1, wr_count[i]);
        end
        check({name, " first write latency"}, 3, first_wr - first_rd);
        check({name, " done after last write"}, last_wr_cyc + 1, done_rise);
        apb_access(1'b0, REG_STATUS, 32'h0, status, err);
        check({name, " status done, not busy"}, 32'h2, status);
        check({name, " status pslverr"}, 0, err);
    endtask

    task automatic compare_image(input string name);
        for (int i = 0; i < NPIX; i++) begin
            check($sformatf("%s word %0d", name, i), ref_word(i), capture[i]);
        end
    endtask

    task automatic check_ramp();
        grad_word_t expected;
        for (int i = 0; i < NPIX; i++) begin
            expected.gx = (i % IMG_W == 0) ? 10'sd0 : 10'sd1;
            expected.gy = (i / IMG_W == 0) ? 10'sd0 : 10'sd16;
            check($sformatf("ramp word %0d", i), expected, capture[i]);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 32'h0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        check("reset img_rd", 0, img_rd);
        check("reset grad_wr", 0, grad_wr);
        check("reset done", 0, done);
        apb_access(1'b0, REG_STATUS, 32'h0, rdata, err);
        check("reset status", 0, rdata);
        check("reset pslverr", 0, err);

        fill_ramp();
        start_scan("ramp");
        finish_scan("ramp");
        check_ramp();

        fill_random();
        start_scan("random");
        finish_scan("random");
        compare_image("random");

        fill_random(); // Second start from the done state.
        start_scan("rerun");
        finish_scan("rerun");
        compare_image("rerun");

        fill_random();
        start_scan("busy start");
        repeat (20) @(negedge clk);
        apb_access(1'b0, REG_STATUS, 32'h0, rdata, err);
        check("busy start status busy", 32'h1, rdata);
        apb_access(1'b1, REG_CTRL, 32'h1, rdata, err);
        check("busy start pslverr", 0, err);
        finish_scan("busy start");
        compare_image("busy start");
        repeat (8) @(negedge clk);
        check("busy start no rerun done", 1, done);
        check("busy start no rerun img_rd", 0, img_rd);
        check("busy start total writes", NPIX, wr_total);

        apb_access(1'b0, 8'h08, 32'h0, rdata, err);
        check("unmapped read pslverr", 1, err);
        check("unmapped read data", 0, rdata);
        apb_access(1'b1, 8'h08, 32'h1, rdata, err);
        check("unmapped write pslverr", 1, err);
        @(negedge clk);
        check("unmapped write ignored done", 1, done);
        check("unmapped write ignored img_rd", 0, img_rd);

        report_and_finish();
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/grad_pkg.sv
hdl/grad_apb_regs.sv
hdl/grad_scan_ctrl.sv
hdl/grad_horiz.sv
hdl/grad_vert.sv
hdl/grad_pack_wr.sv
hdl/grad_top.sv
dv/grad_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module grad_tb -f project.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vgrad_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
